/* bench/tart_checker.sv */
`default_nettype none

module tart_checker (
   input wire                 fpga_clk,
   input wire                 b_rst,
   input wire                 cyc_i,
   input wire                 stb_i,
   input wire                 ack_i,        // slave acknowledge
   input wire                 aq_enable_i,  // control register enable bit
   input wire                 led_i,
   input tart_pkg::aq_state_t state_i
);
   timeunit 1ns;
   timeprecision 1ps;
   import tart_pkg::*;

   // ----------------------------------------
   // bus handshake
   // ----------------------------------------
   // one-cycle ack, one cycle after a new request
   bus_ack_timing: assert property (@(posedge fpga_clk) disable iff (b_rst)
      $rose(cyc_i && stb_i) |=> ack_i ##1 !ack_i)
      else $error("ack not a single cycle right after the request");

   // ----------------------------------------
   // acquisition sequence
   // ----------------------------------------
   enable_starts_fill: assert property (@(posedge fpga_clk) disable iff (b_rst)
      $rose(aq_enable_i) |=> (state_i == AQ_FILL))
      else $error("enable did not start a fill one cycle later");

   // block offered for read-back only once a fill has completed
   led_after_fill: assert property (@(posedge fpga_clk) disable iff (b_rst)
      $rose(led_i) |-> ($past(state_i) == AQ_FILL))
      else $error("led came on without a completed fill");

   done_after_read: assert property (@(posedge fpga_clk) disable iff (b_rst)
      $rose(state_i == AQ_DONE) |-> $past(ack_i))
      else $error("done reached without a bus read");

endmodule

`default_nettype wire

/* bench/tart_monitor.sv */
`default_nettype none

module tart_monitor (
   input wire                           fpga_clk,
   input wire                           b_rst,
   input wire                           cyc_i,
   input wire                           stb_i,
   input wire                           we_i,
   input wire                           ack_i,   // DUT ack_o
   input wire [tart_pkg::BUS_WIDTH-1:0] dat_i    // DUT dat_o
);
   timeunit 1ns;
   timeprecision 1ps;
   import tart_pkg::*;

   string                exp_name_q [$];  // test name per expected read
   logic [BUS_WIDTH-1:0] exp_val_q  [$];
   logic [BUS_WIDTH-1:0] exp_mask_q [$];  // bits that are compared
   logic                 pend_rd;         // a read is waiting for its ack
   int                   error_count = 0;
   int                   check_count = 0;

   // one entry per bus read, in issue order
   task automatic queue_read(input string name, input logic [BUS_WIDTH-1:0] val,
                             input logic [BUS_WIDTH-1:0] mask);
      exp_name_q.push_back(name);
      exp_val_q.push_back(val);
      exp_mask_q.push_back(mask);
   endtask

   task automatic compare_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      check_count++;
      if (exp_v !== act_v) begin
         error_count++;
         $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
      end
   endtask

   function automatic int pending_count();
      return exp_val_q.size();
   endfunction

   // pop the oldest expectation and compare under its mask
   task automatic check_read();
      string                name;
      logic [BUS_WIDTH-1:0] val;
      logic [BUS_WIDTH-1:0] mask;
      if (exp_val_q.size() == 0) begin
         error_count++;
         $display("read acknowledged while no read was expected");
      end else begin
         name = exp_name_q.pop_front();
         val  = exp_val_q.pop_front();
         mask = exp_mask_q.pop_front();
         if (mask != '0) begin  // all-zero mask only keeps the queue in step
            compare_value(name, 32'(val & mask), 32'(dat_i & mask));
         end
      end
   endtask

   // request seen in one cycle, data valid with ack in the next
   always @(posedge fpga_clk) begin
      if (b_rst) begin
         pend_rd <= 1'b0;
      end else begin
         if (ack_i && pend_rd) begin
            check_read();
         end
         if (ack_i) begin
            pend_rd <= 1'b0;
         end else if (cyc_i && stb_i) begin
            pend_rd <= !we_i;  // writes are not compared
         end
      end
   end

endmodule

`default_nettype wire

/* bench/tb_tart_capture.sv */
`default_nettype none

module tb_tart_capture;
   timeunit 1ns;
   timeprecision 1ps;
   import tart_pkg::*;

   localparam int DEPTH_LOG2   = 5;
   localparam int SAMPLE_RATIO = 6;
   localparam int WORDS        = 2 ** DEPTH_LOG2;
   localparam int FILL_CYCLES  = WORDS * SAMPLE_RATIO;
   localparam int READ_CYCLES  = WORDS * 3 * 4;   // 3 bytes a word, up to 4 cycles a read
   // 4 fills and 4 read-backs, doubled, rounded up to a thousand
   localparam int TIMEOUT_CYCLES = ((4 * FILL_CYCLES + 4 * READ_CYCLES) * 2 + 999) / 1000 * 1000;

   logic                    fpga_clk;
   logic                    b_rst;
   logic [SAMPLE_WIDTH-1:0] antenna;
   logic                    cyc;
   logic                    stb;
   logic                    we;
   logic [ADR_WIDTH-1:0]    adr;
   logic [BUS_WIDTH-1:0]    wdata;
   logic [BUS_WIDTH-1:0]    rdata;
   logic                    ack;
   logic                    led;
   logic                    sample_stb;
   logic [SAMPLE_WIDTH-1:0] const_word;    // last constant on the antennas
   int                      cycle_cnt = 0;
   int                      seed;
   int                      tests_run = 0;
   int                      tests_failed = 0;
   int                      err_mark = 0;   // monitor errors before current test

   tart_capture #(.DEPTH_LOG2(DEPTH_LOG2), .SAMPLE_RATIO(SAMPLE_RATIO)) u_dut (
      .fpga_clk     (fpga_clk),
      .b_rst        (b_rst),
      .antenna_i    (antenna),
      .cyc_i        (cyc),
      .stb_i        (stb),
      .we_i         (we),
      .adr_i        (adr),
      .dat_i        (wdata),
      .dat_o        (rdata),
      .ack_o        (ack),
      .led_o        (led),
      .sample_stb_o (sample_stb)
   );

   tart_monitor u_mon (
      .fpga_clk (fpga_clk),
      .b_rst    (b_rst),
      .cyc_i    (cyc),
      .stb_i    (stb),
      .we_i     (we),
      .ack_i    (ack),
      .dat_i    (rdata)
   );

   bind tart_capture tart_checker u_checker (
      .fpga_clk    (fpga_clk),
      .b_rst       (b_rst),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .ack_i       (ack_o),
      .aq_enable_i (aq_enable),
      .led_i       (led_o),
      .state_i     (state)
   );

   initial begin
      fpga_clk = 1'b0;
      forever #5 fpga_clk = ~fpga_clk;  // 100 MHz
   end

   always @(posedge fpga_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run stopped after %0d cycles", cycle_cnt);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // byte idx of a sample word, low byte first
   function automatic logic [7:0] expected_byte(input logic [23:0] word, input int idx);
      logic [23:0] shifted;
      shifted = word >> (8 * idx);
      return shifted[7:0];
   endfunction

   // ----------------------------------------
   // bus master
   // ----------------------------------------
   task automatic write_reg(input logic [2:0] adr_v, input logic [7:0] data_v);
      @(negedge fpga_clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = 1'b1;
      adr   = adr_v;
      wdata = data_v;
      @(negedge fpga_clk);
      while (ack !== 1'b1) @(negedge fpga_clk);  // hold until ack
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic read_reg(input logic [2:0] adr_v, input string name, input logic [7:0] exp_v,
                           input logic [7:0] mask_v, output logic [7:0] data_v);
      u_mon.queue_read(name, exp_v, mask_v);
      @(negedge fpga_clk);
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = adr_v;
      @(negedge fpga_clk);
      while (ack !== 1'b1) @(negedge fpga_clk);
      data_v = rdata;  // valid with ack
      cyc    = 1'b0;
      stb    = 1'b0;
   endtask

   task automatic catch_strobe(output int at_cycle);
      @(negedge fpga_clk);
      while (sample_stb !== 1'b1) @(negedge fpga_clk);
      at_cycle = cycle_cnt;
   endtask

   task automatic wait_led();
      @(negedge fpga_clk);
      while (led !== 1'b1) @(negedge fpga_clk);  // block full
   endtask

   task automatic verify_const_block(input string name, input logic [23:0] word);
      logic [7:0] rd;
      for (int w = 0; w < WORDS; w++) begin
         for (int b = 0; b < 3; b++) begin
            read_reg(REG_DATA, name, expected_byte(word, b), 8'hff, rd);
         end
      end
   endtask

   task automatic finish_test(input string name);
      int errs;
      @(negedge fpga_clk);  // let the last ack be compared
      errs = u_mon.error_count - err_mark;
      tests_run++;
      if (errs == 0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errs);
      end
      err_mark = u_mon.error_count;
   endtask

   // ----------------------------------------
   // tests
   // ----------------------------------------
   task automatic exercise_registers();
      logic [7:0] v;
      logic [7:0] rd;
      logic [7:0] stat_mask;
      for (int i = 0; i < 8; i++) begin
         v = 8'($random(seed));
         write_reg(REG_CTRL, v);
         read_reg(REG_CTRL, "reg_ctrl", {3'b000, v[4:0]}, 8'hff, rd);
         stat_mask = v[0] ? 8'hfc : 8'hff;  // state only known when disabled
         read_reg(REG_STATUS, "reg_status", {1'b1, 2'b00, v[0], v[1], 3'b000}, stat_mask, rd);
      end
      write_reg(REG_CTRL, 8'h00);
      read_reg(3'd5, "reg_unmapped", 8'h00, 8'hff, rd);
      finish_test("reg_access");
   endtask

   task automatic measure_strobe_phase();
      int ref_at;
      int t_a;
      int t_b;
      int t_c;
      write_reg(REG_CTRL, 8'h00);
      catch_strobe(t_a);
      catch_strobe(ref_at);  // delay 0 reference
      for (int d = 0; d < SAMPLE_RATIO; d++) begin
         write_reg(REG_CTRL, 8'(d << 2));
         catch_strobe(t_a);  // may still carry the old phase
         catch_strobe(t_b);
         catch_strobe(t_c);
         u_mon.compare_value("strobe_interval", SAMPLE_RATIO, t_c - t_b);
         u_mon.compare_value("strobe_offset", d, (t_b - ref_at) % SAMPLE_RATIO);
      end
      finish_test("strobe_phase");
   endtask

   task automatic capture_antenna_word();
      const_word = 24'($random(seed));
      @(negedge fpga_clk);
      antenna = const_word;
      write_reg(REG_CTRL, 8'h09);  // delay 2, enable
      wait_led();
      verify_const_block("real_capture", const_word);
      finish_test("real_capture");
   endtask

   task automatic sequence_states();
      logic [7:0] rd;
      int         t;
      read_reg(REG_STATUS, "status_done", 8'h93, 8'hff, rd);
      for (int i = 0; i < 3; i++) begin
         read_reg(REG_DATA, "data_after_done", 8'h00, 8'hff, rd);
      end
      write_reg(REG_CTRL, 8'h08);  // enable off
      @(negedge fpga_clk);
      u_mon.compare_value("led_off", 0, 32'(led));
      read_reg(REG_STATUS, "status_idle", 8'h80, 8'hff, rd);
      // aborted fill puts a third word at the low addresses
      const_word = ~const_word;
      antenna    = const_word ^ 24'h5a_5a5a;
      write_reg(REG_CTRL, 8'h09);
      repeat (4) catch_strobe(t);
      write_reg(REG_CTRL, 8'h08);
      antenna = const_word;  // a refill not from address 0 leaves old words
      write_reg(REG_CTRL, 8'h09);
      wait_led();
      verify_const_block("refill", const_word);
      finish_test("state_sequence");
   endtask

   task automatic count_debug_words();
      logic [7:0]  b0;
      logic [7:0]  b1;
      logic [7:0]  b2;
      logic [7:0]  rd;
      logic [23:0] first;
      write_reg(REG_CTRL, 8'h00);
      write_reg(REG_CTRL, 8'h17);  // delay 5, debug, enable
      wait_led();
      read_reg(REG_DATA, "debug_first", 8'h00, 8'h00, b0);  // start value is free
      read_reg(REG_DATA, "debug_first", 8'h00, 8'h00, b1);
      read_reg(REG_DATA, "debug_first", 8'h00, 8'h00, b2);
      first = {b2, b1, b0};
      for (int w = 1; w < WORDS; w++) begin
         for (int b = 0; b < 3; b++) begin
            read_reg(REG_DATA, "debug_capture", expected_byte(first + 24'(w), b), 8'hff, rd);
         end
      end
      finish_test("debug_capture");
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      seed    = 32'hd588_0764;
      b_rst   = 1'b1;
      antenna = '0;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = '0;
      wdata   = '0;
      const_word = '0;
      repeat (5) @(negedge fpga_clk);
      b_rst = 1'b0;

      exercise_registers();
      measure_strobe_phase();
      capture_antenna_word();
      sequence_states();
      count_debug_words();

      if (u_mon.pending_count() != 0) begin
         $display("%0d expected reads were never acknowledged", u_mon.pending_count());
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, u_mon.check_count, u_mon.error_count);
      if (tests_failed == 0 && u_mon.error_count == 0 && u_mon.pending_count() == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/antenna_sampler.sv */
`default_nettype none

module antenna_sampler #(
   parameter int DEPTH_LOG2 = 9
) (
   input  wire                            fpga_clk,
   input  wire                            b_rst,
   input  wire [tart_pkg::SAMPLE_WIDTH-1:0] antenna_i,   // raw antenna bits
   input  wire                            sample_stb_i,
   input  wire                            debug_i,     // counter instead of antennas
   input  wire                            fill_en_i,   // high during a fill
   output logic                           fill_last_o, // write to last address
   aq_buf_if.writer                       aq_buf
);
   import tart_pkg::*;

   logic [SAMPLE_WIDTH-1:0] ant_q;     // registered antenna word
   logic [SAMPLE_WIDTH-1:0] dbg_cnt;   // debug test pattern
   logic [SAMPLE_WIDTH-1:0] src_word;
   logic [DEPTH_LOG2-1:0]   wr_cnt;
   logic                    wr_go;

   // ----------------------------------------
   // input register and debug counter
   // ----------------------------------------
   always_ff @(posedge fpga_clk) begin
      ant_q <= antenna_i;  // every cycle, strobe just picks one
   end

   // counts strobes whether filling or not
   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         dbg_cnt <= '0;
      end else if (sample_stb_i) begin
         dbg_cnt <= dbg_cnt + 1'b1;  // wraps mod 2^24
      end
   end

   assign src_word = debug_i ? dbg_cnt : ant_q;

   // ----------------------------------------
   // buffer write
   // ----------------------------------------
   assign wr_go = sample_stb_i && fill_en_i;

   // address runs 0 .. depth-1, restarts whenever fill is off
   always_ff @(posedge fpga_clk) begin
      if (b_rst || !fill_en_i) begin
         wr_cnt <= '0;
      end else if (sample_stb_i) begin
         wr_cnt <= wr_cnt + 1'b1;
      end
   end

   assign aq_buf.wr_en   = wr_go;
   assign aq_buf.wr_addr = wr_cnt;
   assign aq_buf.wr_data = src_word;

   // fsm leaves fill on this, so the wrap back to 0 is never written
   assign fill_last_o = wr_go && (&wr_cnt);

endmodule

`default_nettype wire

/* rtl/aq_buf_if.sv */
`default_nettype none

// write and read ports of the block buffer
interface aq_buf_if #(
   parameter int DEPTH_LOG2 = 9
);
   import tart_pkg::*;

   logic                    wr_en;    // one write per sample strobe
   logic [DEPTH_LOG2-1:0]   wr_addr;
   logic [SAMPLE_WIDTH-1:0] wr_data;
   logic [DEPTH_LOG2-1:0]   rd_addr;  // word pointer from the bus side
   logic [SAMPLE_WIDTH-1:0] rd_data;  // one cycle behind rd_addr

   // sampler side
   modport writer (output wr_en, output wr_addr, output wr_data);

   // bus register side
   modport reader (output rd_addr, input rd_data);

   // the RAM itself
   modport mem (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);

endinterface

`default_nettype wire

/* rtl/aq_bus_regs.sv */
`default_nettype none

module aq_bus_regs #(
   parameter int DEPTH_LOG2 = 9
) (
   input  wire                             fpga_clk,
   input  wire                             b_rst,
   input  wire                             cyc_i,
   input  wire                             stb_i,
   input  wire                             we_i,
   input  wire [tart_pkg::ADR_WIDTH-1:0]   adr_i,
   input  wire [tart_pkg::BUS_WIDTH-1:0]   dat_i,
   output logic [tart_pkg::BUS_WIDTH-1:0]  dat_o,
   output logic                            ack_o,
   input  tart_pkg::aq_state_t             state_i,
   output logic                            aq_enable_o,
   output logic                            aq_debug_o,
   output logic [2:0]                      aq_delay_o,
   output logic                            read_last_o, // third byte of last word
   aq_buf_if.reader                        aq_buf
);
   import tart_pkg::*;

   logic                  req;        // new request, first cycle of stb
   logic                  data_rd;    // read-back access in ready state
   logic [1:0]            byte_idx;   // 0, 1, 2 within a word
   logic [DEPTH_LOG2-1:0] rd_ptr;     // current word
   logic [BUS_WIDTH-1:0]  rd_byte;
   logic [BUS_WIDTH-1:0]  ctrl_word;
   logic [BUS_WIDTH-1:0]  stat_word;

   // ----------------------------------------
   // bus handshake
   // ----------------------------------------
   // ack goes out one cycle after stb, never two in a row
   assign req     = cyc_i && stb_i && !ack_o;
   assign data_rd = req && !we_i && (adr_i == REG_DATA) && (state_i == AQ_READY);

   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= req;
      end
   end

   // ----------------------------------------
   // control register
   // ----------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         aq_enable_o <= 1'b0;
         aq_debug_o  <= 1'b0;
         aq_delay_o  <= 3'd0;
      end else if (req && we_i && (adr_i == REG_CTRL)) begin
         aq_enable_o <= dat_i[0];
         aq_debug_o  <= dat_i[1];
         aq_delay_o  <= dat_i[4:2];  // strobe phase
      end
   end

   assign ctrl_word = {3'b000, aq_delay_o, aq_debug_o, aq_enable_o};
   assign stat_word = {1'b1, 2'b00, aq_enable_o, aq_debug_o, 1'b0, state_i};

   // ----------------------------------------
   // read-back pointer
   // ----------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (b_rst || (state_i == AQ_IDLE)) begin
         byte_idx <= 2'd0;
         rd_ptr   <= '0;
      end else if (data_rd) begin
         if (byte_idx == 2'd2) begin
            byte_idx <= 2'd0;
            rd_ptr   <= rd_ptr + 1'b1;  // next word, RAM catches up in one cycle
         end else begin
            byte_idx <= byte_idx + 1'b1;
         end
      end
   end

   assign aq_buf.rd_addr = rd_ptr;

   // low byte first
   always_comb begin
      case (byte_idx)
         2'd0:    rd_byte = aq_buf.rd_data[7:0];
         2'd1:    rd_byte = aq_buf.rd_data[15:8];
         default: rd_byte = aq_buf.rd_data[23:16];
      endcase
   end

   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         read_last_o <= 1'b0;
      end else begin
         read_last_o <= data_rd && (byte_idx == 2'd2) && (&rd_ptr);
      end
   end

   // ----------------------------------------
   // read data, valid with ack
   // ----------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (req) begin
         case (adr_i)
            REG_CTRL:   dat_o <= ctrl_word;
            REG_STATUS: dat_o <= stat_word;
            REG_DATA:   dat_o <= data_rd ? rd_byte : '0;  // zero outside ready
            default:    dat_o <= '0;                      // unmapped
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/aq_fsm.sv */
`default_nettype none

module aq_fsm (
   input  wire                 fpga_clk,
   input  wire                 b_rst,
   input  wire                 aq_enable_i,  // control register enable bit
   input  wire                 fill_last_i,  // last buffer address written
   input  wire                 read_last_i,  // last byte read back
   output tart_pkg::aq_state_t state_o,
   output logic                fill_en_o
);
   import tart_pkg::*;

   aq_state_t state_q;
   aq_state_t state_d;

   // ----------------------------------------
   // next state
   // ----------------------------------------
   always_comb begin
      state_d = state_q;
      if (!aq_enable_i) begin
         state_d = AQ_IDLE;  // enable low aborts from anywhere
      end else begin
         case (state_q)
            AQ_IDLE: begin
               state_d = AQ_FILL;  // armed
            end
            AQ_FILL: begin
               if (fill_last_i) begin
                  state_d = AQ_READY;
               end
            end
            AQ_READY: begin
               if (read_last_i) begin
                  state_d = AQ_DONE;
               end
            end
            AQ_DONE: begin
               state_d = AQ_DONE;  // stays until enable is cleared
            end
            default: begin
               state_d = AQ_IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------
   // state register
   // ----------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         state_q <= AQ_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign state_o   = state_q;
   assign fill_en_o = (state_q == AQ_FILL);  // sampler writes only here

endmodule

`default_nettype wire

/* rtl/block_buffer.sv */
`default_nettype none

module block_buffer #(
   parameter int DEPTH_LOG2 = 9
) (
   input  wire   fpga_clk,
   aq_buf_if.mem aq_buf
);
   import tart_pkg::*;

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   logic [SAMPLE_WIDTH-1:0] mem [DEPTH];  // inferred block RAM

   // write port, one word per strobe
   always_ff @(posedge fpga_clk) begin
      if (aq_buf.wr_en) begin
         mem[aq_buf.wr_addr] <= aq_buf.wr_data;
      end
   end

   // registered read, data one cycle after the address
   always_ff @(posedge fpga_clk) begin
      aq_buf.rd_data <= mem[aq_buf.rd_addr];
   end

endmodule

`default_nettype wire

/* rtl/sample_timer.sv */
`default_nettype none

module sample_timer #(
   parameter int SAMPLE_RATIO = 6
) (
   input  wire       fpga_clk,
   input  wire       b_rst,
   input  wire [2:0] delay_i,      // phase of the strobe within a period
   output logic      sample_stb_o
);

   // enough bits to count one sample period
   localparam int CNT_W = (SAMPLE_RATIO > 1) ? $clog2(SAMPLE_RATIO) : 1;

   logic [CNT_W-1:0] phase;

   // free-running phase counter, 0 .. SAMPLE_RATIO-1
   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         phase <= '0;
      end else if (int'(phase) == SAMPLE_RATIO - 1) begin
         phase <= '0;  // wrap, next period
      end else begin
         phase <= phase + 1'b1;
      end
   end

   // strobe on the selected phase only
   // a delay past the last phase never matches, so no strobe at all
   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         sample_stb_o <= 1'b0;
      end else begin
         sample_stb_o <= (int'(phase) == int'(delay_i));
      end
   end

endmodule

`default_nettype wire

/* rtl/tart_capture.sv */
`default_nettype none

module tart_capture #(
   parameter int DEPTH_LOG2   = 9,  // buffer holds 2^DEPTH_LOG2 samples
   parameter int SAMPLE_RATIO = 6   // fpga_clk cycles per sample
) (
   input  wire                              fpga_clk,
   input  wire                              b_rst,
   input  wire [tart_pkg::SAMPLE_WIDTH-1:0] antenna_i,
   input  wire                              cyc_i,
   input  wire                              stb_i,
   input  wire                              we_i,
   input  wire [tart_pkg::ADR_WIDTH-1:0]    adr_i,
   input  wire [tart_pkg::BUS_WIDTH-1:0]    dat_i,
   output logic [tart_pkg::BUS_WIDTH-1:0]   dat_o,
   output logic                             ack_o,
   output logic                             led_o,        // block ready or read
   output logic                             sample_stb_o  // sample strobe test pin
);
   import tart_pkg::*;

   logic      sample_stb;
   logic      aq_enable;
   logic      aq_debug;
   logic [2:0] aq_delay;
   logic      fill_en;
   logic      fill_last;
   logic      read_last;
   aq_state_t state;

   aq_buf_if #(.DEPTH_LOG2(DEPTH_LOG2)) u_aq_buf ();

   // ----------------------------------------
   // sample path
   // ----------------------------------------
   sample_timer #(.SAMPLE_RATIO(SAMPLE_RATIO)) u_timer (
      .fpga_clk     (fpga_clk),
      .b_rst        (b_rst),
      .delay_i      (aq_delay),
      .sample_stb_o (sample_stb)
   );

   antenna_sampler #(.DEPTH_LOG2(DEPTH_LOG2)) u_sampler (
      .fpga_clk     (fpga_clk),
      .b_rst        (b_rst),
      .antenna_i    (antenna_i),
      .sample_stb_i (sample_stb),
      .debug_i      (aq_debug),
      .fill_en_i    (fill_en),
      .fill_last_o  (fill_last),
      .aq_buf       (u_aq_buf.writer)
   );

   block_buffer #(.DEPTH_LOG2(DEPTH_LOG2)) u_buffer (
      .fpga_clk (fpga_clk),
      .aq_buf   (u_aq_buf.mem)
   );

   // ----------------------------------------
   // control and read-back
   // ----------------------------------------
   aq_fsm u_fsm (
      .fpga_clk    (fpga_clk),
      .b_rst       (b_rst),
      .aq_enable_i (aq_enable),
      .fill_last_i (fill_last),
      .read_last_i (read_last),
      .state_o     (state),
      .fill_en_o   (fill_en)
   );

   aq_bus_regs #(.DEPTH_LOG2(DEPTH_LOG2)) u_regs (
      .fpga_clk    (fpga_clk),
      .b_rst       (b_rst),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .we_i        (we_i),
      .adr_i       (adr_i),
      .dat_i       (dat_i),
      .dat_o       (dat_o),
      .ack_o       (ack_o),
      .state_i     (state),
      .aq_enable_o (aq_enable),
      .aq_debug_o  (aq_debug),
      .aq_delay_o  (aq_delay),
      .read_last_o (read_last),
      .aq_buf      (u_aq_buf.reader)
   );

   assign sample_stb_o = sample_stb;
   assign led_o = (state == AQ_READY) || (state == AQ_DONE);  // data available

endmodule

`default_nettype wire

/* rtl/tart_pkg.sv */
`default_nettype none

package tart_pkg;

   // ----------------------------------------
   // bus and sample widths
   // ----------------------------------------
   localparam int BUS_WIDTH    = 8;   // register bus data
   localparam int ADR_WIDTH    = 3;   // register select
   localparam int SAMPLE_WIDTH = 24;  // one bit per antenna

   // ----------------------------------------
   // register map
   // ----------------------------------------
   localparam logic [ADR_WIDTH-1:0] REG_CTRL   = 3'd0;  // enable, debug, delay
   localparam logic [ADR_WIDTH-1:0] REG_STATUS = 3'd1;  // flags and state
   localparam logic [ADR_WIDTH-1:0] REG_DATA   = 3'd2;  // byte-wise read-back

   // acquisition sequence
   // idle -> fill -> ready -> done, back to idle when enable drops
   typedef enum logic [1:0] {
      AQ_IDLE  = 2'd0,  // waiting for enable
      AQ_FILL  = 2'd1,  // writing samples into the buffer
      AQ_READY = 2'd2,  // block full, read-back open
      AQ_DONE  = 2'd3   // whole block read
   } aq_state_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the capture testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --timescale 1ns/1ps \
   --top-module tb_tart_capture \
   -Mdir obj_dir \
   -f tart_capture.f

# the run may stop early on a failed assertion, the log decides
./obj_dir/Vtb_tart_capture | tee "$LOG"

if grep -q "ALL TESTS PASSED" "$LOG"; then
   echo "simulation ok"
   exit 0
else
   echo "simulation failed, see $LOG"
   exit 1
fi

/* tart_capture.f */
rtl/tart_pkg.sv
rtl/aq_buf_if.sv
rtl/sample_timer.sv
rtl/antenna_sampler.sv
rtl/block_buffer.sv
rtl/aq_fsm.sv
rtl/aq_bus_regs.sv
rtl/tart_capture.sv
bench/tart_checker.sv
bench/tart_monitor.sv
bench/tb_tart_capture.sv
